//--- common/clic_params.svh
// clic sizing macros and the register address map
// each line region holds one byte per line, four lines to a 32-bit word
`ifndef CLIC_PARAMS_SVH
`define CLIC_PARAMS_SVH

`define CLIC_NUM_INT  16
`define CLIC_ID_W     4
`define CLIC_LVL_W    8

// region bases, line 4w+k sits in byte k of word w
`define CLIC_IP_BASE  16'h000
`define CLIC_IE_BASE  16'h100
`define CLIC_CFG_BASE 16'h200

// threshold lives in byte 0 of this word
`define CLIC_TH_ADDR  16'h300

`endif

//--- common/clic_pkg.sv
// clic shared types: level and id fields, register region opcodes, trigger kinds
`default_nettype none
`include "clic_params.svh"

package clic_pkg;

  typedef logic [`CLIC_LVL_W-1:0] clic_lvl_t;
  typedef logic [`CLIC_ID_W-1:0]  clic_id_t;

  // decoded bus region
  typedef enum logic [2:0] {
    REG_IP,
    REG_IE,
    REG_CFG,
    REG_TH,
    REG_NONE
  } clic_reg_e;

  typedef enum logic {
    TRIG_LEVEL = 1'b0,
    TRIG_EDGE  = 1'b1
  } clic_trig_e;

endpackage

`default_nettype wire

//--- rtl/clic_reg_if.sv
// clic register bus slave
// decodes the ip/ie/cfg/th regions, drives per-line write strobes and
// returns read data together with a one-cycle completion pulse
`timescale 1ns/1ps
`default_nettype none
`include "clic_params.svh"

module clic_reg_if
  import clic_pkg::*;
(
  input  logic                          forever_cpuclk,
  input  logic                          arst_n,
  input  logic                          bus_sel,
  input  logic                          bus_write,
  input  logic [15:0]                   bus_addr,
  input  logic [31:0]                   bus_wdata,
  input  logic [`CLIC_NUM_INT-1:0]      ip,
  input  logic [`CLIC_NUM_INT-1:0]      ie,
  input  clic_lvl_t [`CLIC_NUM_INT-1:0] cfg,
  output logic                          bus_cmplt,
  output logic [31:0]                   bus_rdata,
  output logic [`CLIC_NUM_INT-1:0]      ip_wr,
  output logic [`CLIC_NUM_INT-1:0]      ie_wr,
  output logic [`CLIC_NUM_INT-1:0]      cfg_wr,
  output logic [`CLIC_NUM_INT-1:0][7:0] wr_byte,
  output clic_lvl_t                     th
);

  clic_reg_e   reg_op;
  logic [5:0]  word_idx;
  logic        in_lines;
  logic        wr_en;
  logic [31:0] rd_word;

  // only aligned words inside the populated part of a region are mapped
  assign in_lines = (bus_addr[7:0] < 8'(`CLIC_NUM_INT)) && (bus_addr[1:0] == 2'b00);
  assign word_idx = bus_addr[7:2];
  assign wr_en    = bus_sel && bus_write;

  always_comb
  begin
    reg_op = REG_NONE;
    if (({bus_addr[15:8], 8'h00} == `CLIC_IP_BASE) && in_lines)
      reg_op = REG_IP;
    else if (({bus_addr[15:8], 8'h00} == `CLIC_IE_BASE) && in_lines)
      reg_op = REG_IE;
    else if (({bus_addr[15:8], 8'h00} == `CLIC_CFG_BASE) && in_lines)
      reg_op = REG_CFG;
    else if (bus_addr == `CLIC_TH_ADDR)
      reg_op = REG_TH;
  end

  // strobes for the four lines of the addressed word, sampled by the gates
  // at the edge that raises bus_cmplt
  always_comb
  begin
    ip_wr  = '0;
    ie_wr  = '0;
    cfg_wr = '0;
    for (int i = 0; i < `CLIC_NUM_INT; i++)
    begin
      wr_byte[i] = bus_wdata[8*(i%4) +: 8];
      if (wr_en && (word_idx == 6'(i / 4)))
      begin
        ip_wr[i]  = (reg_op == REG_IP);
        ie_wr[i]  = (reg_op == REG_IE);
        cfg_wr[i] = (reg_op == REG_CFG);
      end
    end
  end

  always_comb
  begin
    rd_word = '0;
    if (reg_op == REG_TH)
      rd_word[7:0] = th;
    for (int i = 0; i < `CLIC_NUM_INT; i++)
    begin
      if (word_idx == 6'(i / 4))
      begin
        case (reg_op)
          REG_IP:  rd_word[8*(i%4) +: 8] = {7'b0, ip[i]};
          REG_IE:  rd_word[8*(i%4) +: 8] = {7'b0, ie[i]};
          REG_CFG: rd_word[8*(i%4) +: 8] = cfg[i];
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge forever_cpuclk or negedge arst_n)
  begin
    if (!arst_n)
      th <= '0;
    else if (wr_en && (reg_op == REG_TH))
      th <= bus_wdata[7:0];
  end

  always_ff @(posedge forever_cpuclk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      bus_cmplt <= 1'b0;
      bus_rdata <= '0;
    end
    else
    begin
      bus_cmplt <= bus_sel;
      bus_rdata <= (bus_sel && !bus_write) ? rd_word : '0; // zero outside a read pulse
    end
  end

  // every completion answers an access from the cycle before
  a_cmplt_follows_sel: assert property (@(posedge forever_cpuclk) disable iff (!arst_n)
    bus_cmplt |-> $past(bus_sel));

endmodule

`default_nettype wire

//--- clic_gate/clic_int_gate.sv
// clic per-line gate
// samples the interrupt line and holds its pending, enable and level state
`timescale 1ns/1ps
`default_nettype none
`include "clic_params.svh"

module clic_int_gate
  import clic_pkg::*;
(
  input  logic       forever_cpuclk,
  input  logic       arst_n,
  input  clic_id_t   line_id,
  input  logic       int_vld,
  input  clic_trig_e int_trig,
  input  logic       ip_wr,
  input  logic       ie_wr,
  input  logic       cfg_wr,
  input  logic [7:0] wr_byte,
  input  logic       cpu_int_exit,
  input  clic_id_t   cpu_curid,
  output logic       ip,
  output logic       ie,
  output clic_lvl_t  cfg
);

  logic vld_q;
  logic vld_d;
  logic rise;
  logic set_ip;
  logic clr_ip;
  logic ip_nxt;

  // vld_q is the sampled line, vld_d its value one cycle earlier
  always_ff @(posedge forever_cpuclk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      vld_q <= 1'b0;
      vld_d <= 1'b0;
    end
    else
    begin
      vld_q <= int_vld;
      vld_d <= vld_q;
    end
  end

  assign rise   = vld_q && !vld_d;
  assign set_ip = rise || (ip_wr && wr_byte[0]);
  assign clr_ip = (ip_wr && !wr_byte[0]) || (cpu_int_exit && (cpu_curid == line_id));

  always_comb
  begin
    if (int_trig == TRIG_LEVEL)
      ip_nxt = vld_q; // level lines just track the line
    else if (set_ip)
      ip_nxt = 1'b1;  // a new edge is never lost to a clear in the same cycle
    else if (clr_ip)
      ip_nxt = 1'b0;
    else
      ip_nxt = ip;
  end

  always_ff @(posedge forever_cpuclk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      ip  <= 1'b0;
      ie  <= 1'b0;
      cfg <= '0;
    end
    else
    begin
      ip <= ip_nxt;
      if (ie_wr)
        ie <= wr_byte[0];
      if (cfg_wr)
        cfg <= wr_byte;
    end
  end

  a_level_tracks_line: assert property (@(posedge forever_cpuclk) disable iff (!arst_n)
    (int_trig == TRIG_LEVEL) |=> (ip == $past(vld_q)));

endmodule

`default_nettype wire

//--- rtl/clic_arb.sv
// clic arbiter
// picks the pending, enabled line with the highest level and registers the
// request when that level is above the threshold
`timescale 1ns/1ps
`default_nettype none
`include "clic_params.svh"

module clic_arb
  import clic_pkg::*;
(
  input  logic                          forever_cpuclk,
  input  logic                          arst_n,
  input  logic [`CLIC_NUM_INT-1:0]      ip,
  input  logic [`CLIC_NUM_INT-1:0]      ie,
  input  clic_lvl_t [`CLIC_NUM_INT-1:0] cfg,
  input  clic_lvl_t                     th,
  output logic                          int_req,
  output clic_id_t                      int_id,
  output clic_lvl_t                     int_il
);

  logic      best_vld;
  clic_id_t  best_id;
  clic_lvl_t best_lvl;
  logic      req_nxt;

  // scan from id 0 upwards and only replace on a strictly higher level,
  // so the lowest id keeps a tie
  always_comb
  begin
    best_vld = 1'b0;
    best_id  = '0;
    best_lvl = '0;
    for (int i = 0; i < `CLIC_NUM_INT; i++)
    begin
      if (ip[i] && ie[i] && (!best_vld || (cfg[i] > best_lvl)))
      begin
        best_vld = 1'b1;
        best_id  = clic_id_t'(i);
        best_lvl = cfg[i];
      end
    end
  end

  assign req_nxt = best_vld && (best_lvl > th); // equal to threshold is masked

  always_ff @(posedge forever_cpuclk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      int_req <= 1'b0;
      int_id  <= '0;
      int_il  <= '0;
    end
    else
    begin
      int_req <= req_nxt;
      int_id  <= req_nxt ? best_id : '0;
      int_il  <= req_nxt ? best_lvl : '0;
    end
  end

  // th is the threshold seen when the request was registered
  a_req_above_th: assert property (@(posedge forever_cpuclk) disable iff (!arst_n)
    int_req |-> (int_il > $past(th)));

endmodule

`default_nettype wire

//--- rtl/clic_top.sv
// clic top level
// bus register interface, one gate per interrupt line and the output arbiter
`timescale 1ns/1ps
`default_nettype none
`include "clic_params.svh"

module clic_top
  import clic_pkg::*;
(
  input  logic                     forever_cpuclk,
  input  logic                     arst_n,
  input  logic [`CLIC_NUM_INT-1:0] int_vld,
  input  logic [`CLIC_NUM_INT-1:0] int_cfg,   // 1 marks an edge line
  input  logic                     bus_sel,
  input  logic                     bus_write,
  input  logic [15:0]              bus_addr,
  input  logic [31:0]              bus_wdata,
  input  clic_id_t                 cpu_curid,
  input  logic                     cpu_int_exit,
  output logic                     bus_cmplt,
  output logic [31:0]              bus_rdata,
  output logic                     int_req,
  output clic_id_t                 int_id,
  output clic_lvl_t                int_il
);

  logic [`CLIC_NUM_INT-1:0]      ip;
  logic [`CLIC_NUM_INT-1:0]      ie;
  clic_lvl_t [`CLIC_NUM_INT-1:0] cfg;
  logic [`CLIC_NUM_INT-1:0]      ip_wr;
  logic [`CLIC_NUM_INT-1:0]      ie_wr;
  logic [`CLIC_NUM_INT-1:0]      cfg_wr;
  logic [`CLIC_NUM_INT-1:0][7:0] wr_byte;
  clic_lvl_t                     th;

  clic_reg_if x_clic_reg_if (
    .forever_cpuclk (forever_cpuclk),
    .arst_n         (arst_n),
    .bus_sel        (bus_sel),
    .bus_write      (bus_write),
    .bus_addr       (bus_addr),
    .bus_wdata      (bus_wdata),
    .ip             (ip),
    .ie             (ie),
    .cfg            (cfg),
    .bus_cmplt      (bus_cmplt),
    .bus_rdata      (bus_rdata),
    .ip_wr          (ip_wr),
    .ie_wr          (ie_wr),
    .cfg_wr         (cfg_wr),
    .wr_byte        (wr_byte),
    .th             (th)
  );

  for (genvar i = 0; i < `CLIC_NUM_INT; i++)
  begin : int_gate
    clic_int_gate x_clic_int_gate (
      .forever_cpuclk (forever_cpuclk),
      .arst_n         (arst_n),
      .line_id        (clic_id_t'(i)),
      .int_vld        (int_vld[i]),
      .int_trig       (clic_trig_e'(int_cfg[i])),
      .ip_wr          (ip_wr[i]),
      .ie_wr          (ie_wr[i]),
      .cfg_wr         (cfg_wr[i]),
      .wr_byte        (wr_byte[i]),
      .cpu_int_exit   (cpu_int_exit),
      .cpu_curid      (cpu_curid),
      .ip             (ip[i]),
      .ie             (ie[i]),
      .cfg            (cfg[i])
    );
  end

  clic_arb x_clic_arb (
    .forever_cpuclk (forever_cpuclk),
    .arst_n         (arst_n),
    .ip             (ip),
    .ie             (ie),
    .cfg            (cfg),
    .th             (th),
    .int_req        (int_req),
    .int_id         (int_id),
    .int_il         (int_il)
  );

endmodule

`default_nettype wire

//--- sim/clic_clk_gen.sv
// clic testbench clock and reset
// free-running 100 ns clock, reset held low for the first 8 cycles
`timescale 1ns/1ps
`default_nettype none

module clic_clk_gen
(
  output logic clk,
  output logic arst_n
);

  localparam int HALF_PERIOD  = 50;
  localparam int RESET_CYCLES = 8;

  initial
  begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

  initial
  begin
    arst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1; // released away from the active edge
  end

endmodule

`default_nettype wire

//--- sim/clic_tb.sv
// clic testbench
// applies a table of bus accesses, line changes and output checks, with the
// expected request worked out from a line-level model of the controller
`timescale 1ns/1ps
`default_nettype none
`include "clic_params.svh"

module clic_tb
  import clic_pkg::*;
();

  typedef enum int {ACT_WR, ACT_RD, ACT_LINES, ACT_EXIT, ACT_OUT} act_e;

  localparam logic [15:0] EDGE_LINES  = 16'h8000; // line 15 is the only edge line
  localparam int          TIMEOUT_CYC = 2000;     // 64 rows of up to 6 cycles plus reset

  logic                     forever_cpuclk;
  logic                     arst_n;
  logic [`CLIC_NUM_INT-1:0] int_vld;
  logic [`CLIC_NUM_INT-1:0] int_cfg;
  logic                     bus_sel;
  logic                     bus_write;
  logic [15:0]              bus_addr;
  logic [31:0]              bus_wdata;
  clic_id_t                 cpu_curid;
  logic                     cpu_int_exit;
  logic                     bus_cmplt;
  logic [31:0]              bus_rdata;
  logic                     int_req;
  clic_id_t                 int_id;
  clic_lvl_t                int_il;

  // the data column also carries the line mask of a line row
  string       r_name[$];
  act_e        r_act[$];
  logic [15:0] r_addr[$];
  logic [31:0] r_data[$];
  logic [31:0] r_exp[$];

  logic [`CLIC_NUM_INT-1:0] m_lines;
  logic [`CLIC_NUM_INT-1:0] m_edge_ip;
  logic [`CLIC_NUM_INT-1:0] m_ie;
  clic_lvl_t                m_lvl [`CLIC_NUM_INT];
  clic_lvl_t                m_th;

  integer seed = 32'hd371;
  int     errors = 0;
  int     checks = 0;
  int     cycles = 0;

  clic_clk_gen clk_gen (.clk(forever_cpuclk), .arst_n(arst_n));

  clic_top DUT (.*);

  task automatic add_row(input string name, input act_e act, input logic [15:0] addr,
                         input logic [31:0] data, input logic [31:0] exp);
    r_name.push_back(name);
    r_act.push_back(act);
    r_addr.push_back(addr);
    r_data.push_back(data);
    r_exp.push_back(exp);
  endtask

  task automatic write_reg(input string name, input logic [15:0] addr, input logic [31:0] data);
    int line;
    add_row(name, ACT_WR, addr, data, 32'h0);
    if (addr == `CLIC_TH_ADDR)
      m_th = data[7:0];
    else if ((addr[7:0] < 8'(`CLIC_NUM_INT)) && (addr[1:0] == 2'b00))
    begin
      for (int k = 0; k < 4; k++)
      begin
        line = 4 * int'(addr[7:2]) + k;
        case ({addr[15:8], 8'h00})
          `CLIC_IP_BASE:
            if (EDGE_LINES[line])
              m_edge_ip[line] = data[8*k]; // level lines ignore ip writes
          `CLIC_IE_BASE:
            m_ie[line] = data[8*k];
          `CLIC_CFG_BASE:
            m_lvl[line] = data[8*k +: 8];
          default: ;
        endcase
      end
    end
  endtask

  task automatic set_lines(input string name, input logic [15:0] mask);
    add_row(name, ACT_LINES, 16'h0, {16'h0, mask}, 32'h0);
    m_edge_ip = m_edge_ip | (mask & ~m_lines & EDGE_LINES);
    m_lines   = mask;
  endtask

  task automatic exit_line(input string name, input int id);
    add_row(name, ACT_EXIT, 16'(id), 32'h0, 32'h0);
    m_edge_ip[id] = 1'b0;
  endtask

  task automatic check_read(input string name, input logic [15:0] addr, input logic [31:0] exp);
    add_row(name, ACT_RD, addr, 32'h0, exp);
  endtask

  // scanning down from the top line and taking any level at least as high
  // leaves the lowest id among the highest levels
  function automatic logic [31:0] expected_out();
    logic [`CLIC_NUM_INT-1:0] cand;
    int                       win;
    cand = ((m_lines & ~EDGE_LINES) | (m_edge_ip & EDGE_LINES)) & m_ie;
    win  = -1;
    for (int i = `CLIC_NUM_INT - 1; i >= 0; i--)
    begin
      if (cand[i] && ((win < 0) || (m_lvl[i] >= m_lvl[win])))
        win = i;
    end
    if ((win < 0) || (m_lvl[win] <= m_th))
      return 32'h0;
    return {19'h0, 1'b1, 4'(win), m_lvl[win]};
  endfunction

  task automatic check_out(input string name);
    add_row(name, ACT_OUT, 16'h0, 32'h0, expected_out());
  endtask

  task automatic build_table();
    check_out("reset idle");
    check_read("ie after reset", `CLIC_IE_BASE, 32'h0);
    write_reg("ie word 0", `CLIC_IE_BASE, 32'h000100ff);
    check_read("ie keeps bit 0", `CLIC_IE_BASE, 32'h00010001);
    write_reg("cfg word 0", `CLIC_CFG_BASE, 32'h40302010);
    check_read("cfg word 0", `CLIC_CFG_BASE, 32'h40302010);
    write_reg("cfg word 3", `CLIC_CFG_BASE + 16'hc, 32'hf0e0d0c0);
    check_read("cfg word 3", `CLIC_CFG_BASE + 16'hc, 32'hf0e0d0c0);
    write_reg("threshold", `CLIC_TH_ADDR, 32'hffffff20);
    check_read("threshold byte 0", `CLIC_TH_ADDR, 32'h20);
    write_reg("unmapped write", `CLIC_IE_BASE + 16'h10, 32'hffffffff);
    check_read("ie unchanged", `CLIC_IE_BASE, 32'h00010001);
    check_read("unmapped region", 16'h0400, 32'h0);
    check_read("past last line", `CLIC_CFG_BASE + 16'h10, 32'h0);

    set_lines("line 2 high", 16'h0004);
    check_out("line 2 request");
    set_lines("line 2 low", 16'h0000);
    check_out("line 2 dropped");

    set_lines("line 0 high", 16'h0001);
    check_out("below threshold");
    write_reg("threshold at level", `CLIC_TH_ADDR, 32'h10);
    check_out("equal threshold");
    write_reg("threshold lowered", `CLIC_TH_ADDR, 32'h0f);
    check_out("threshold lowered");
    set_lines("line 0 low", 16'h0000);

    write_reg("threshold zero", `CLIC_TH_ADDR, 32'h0);
    write_reg("ie word 1", `CLIC_IE_BASE + 16'h4, 32'h01010101);
    for (int n = 0; n < 4; n++)
    begin
      write_reg("random levels", `CLIC_CFG_BASE + 16'h4, $random(seed));
      set_lines("random lines", 16'h00f0 & ~(16'h0008 << n));
      check_out("random winner");
    end
    write_reg("equal levels", `CLIC_CFG_BASE + 16'h4, 32'h77777777);
    set_lines("tie four lines", 16'h00f0);
    check_out("tie lowest id");
    set_lines("tie upper three", 16'h00e0);
    check_out("tie next id");
    set_lines("lines 4 to 7 low", 16'h0000);

    write_reg("ie word 3", `CLIC_IE_BASE + 16'hc, 32'h01000000);
    set_lines("line 15 pulse", 16'h8000);
    set_lines("line 15 pulse end", 16'h0000);
    check_out("edge stays pending");
    check_read("ip shows edge", `CLIC_IP_BASE + 16'hc, 32'h01000000);
    exit_line("exit other id", 14);
    check_out("wrong exit ignored");
    exit_line("exit line 15", 15);
    check_out("exit clears edge");
    check_read("ip cleared", `CLIC_IP_BASE + 16'hc, 32'h0);
    write_reg("ip write set", `CLIC_IP_BASE + 16'hc, 32'h01000000);
    check_out("ip write sets");
    write_reg("ip write clear", `CLIC_IP_BASE + 16'hc, 32'h0);
    check_out("ip write clears");
    write_reg("ip write level lines", `CLIC_IP_BASE, 32'h01010101);
    check_read("level ip ignored", `CLIC_IP_BASE, 32'h0);
    set_lines("line 2 high again", 16'h0004);
    check_out("line 2 again");
    check_read("ip tracks level line", `CLIC_IP_BASE, 32'h00010000);
  endtask

  // one access per call, driven just after a rising edge
  task automatic bus_access(input logic wr, input logic [15:0] addr, input logic [31:0] data,
                            output logic [31:0] rdata);
    int waited;
    bus_sel   = 1'b1;
    bus_write = wr;
    bus_addr  = addr;
    bus_wdata = data;
    @(posedge forever_cpuclk);
    #1;
    bus_sel   = 1'b0;
    bus_write = 1'b0;
    waited    = 0;
    while (!bus_cmplt && (waited < 4))
    begin
      @(posedge forever_cpuclk);
      #1;
      waited++;
    end
    checks++;
    assert (bus_cmplt) else
    begin
      errors++;
      $display("bus access to address %h got no completion pulse", addr);
    end
    rdata = bus_rdata;
  endtask

  task automatic run_row(input int r);
    logic [31:0] got;
    got = '0;
    case (r_act[r])
      ACT_WR:
        bus_access(1'b1, r_addr[r], r_data[r], got);
      ACT_RD:
        bus_access(1'b0, r_addr[r], 32'h0, got);
      ACT_LINES:
      begin
        int_vld = r_data[r][15:0];
        @(posedge forever_cpuclk);
        #1;
      end
      ACT_EXIT:
      begin
        cpu_curid    = r_addr[r][3:0];
        cpu_int_exit = 1'b1;
        @(posedge forever_cpuclk);
        #1;
        cpu_int_exit = 1'b0;
      end
      ACT_OUT:
      begin
        repeat (4) @(posedge forever_cpuclk);
        #1;
        got = {19'h0, int_req, int_id, int_il}; // same packing as expected_out
      end
    endcase
    if (r_act[r] inside {ACT_RD, ACT_OUT})
    begin
      checks++;
      assert (got === r_exp[r]) else
      begin
        errors++;
        $display("FAIL %s: expected %h, actual %h", r_name[r], r_exp[r], got);
      end
    end
  endtask

  always @(posedge forever_cpuclk)
  begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYC)
    begin
      $display("run stopped after %0d cycles without finishing the table", cycles);
      $display("TEST FAILED");
      $finish;
    end
  end

  initial
  begin
    int_vld      = '0;
    int_cfg      = EDGE_LINES;
    bus_sel      = 1'b0;
    bus_write    = 1'b0;
    bus_addr     = '0;
    bus_wdata    = '0;
    cpu_curid    = '0;
    cpu_int_exit = 1'b0;
    m_lines      = '0;
    m_edge_ip    = '0;
    m_ie         = '0;
    m_lvl        = '{default: '0};
    m_th         = '0;
    build_table();
    @(posedge arst_n);
    @(posedge forever_cpuclk);
    #1;
    for (int r = 0; r < r_name.size(); r++)
      run_row(r);
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("TEST OK");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- project.f
+incdir+common
common/clic_pkg.sv
rtl/clic_reg_if.sv
clic_gate/clic_int_gate.sv
rtl/clic_arb.sv
rtl/clic_top.sv
sim/clic_clk_gen.sv
sim/clic_tb.sv

//--- Makefile
TOP = clic_tb

all: run

build:
	verilator --binary --assert -j 0 --top-module $(TOP) -f project.f

run: build
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "TEST OK"

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f project.f

clean:
	rm -rf obj_dir

.PHONY: all build run lint clean
